//--- verilog/nand_pkg.sv
package nand_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and register map
  //////////////////////////////////////////////////////////////////////

  localparam int REG_ADDR_W = 12;
  localparam int FIFO_CNT_W = 32;
  localparam int FIELD_W    = 12;

  // ID bytes sit at consecutive addresses from the base
  localparam logic [REG_ADDR_W-1:0] REG_ID_BASE = 12'h800;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS  = 12'h806;

  // delays in clk cycles
  localparam int T_CLR_CYC = 3;
  localparam int T_WB_CYC  = 25;
  // counter just wide enough to reach the longer delay
  localparam int TMR_CNT_W = $clog2(T_WB_CYC + 1);

  //////////////////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    OP_NONE, OP_RESET, OP_STATUS, OP_READ_ID, OP_ERASE, OP_PROGRAM, OP_PAGE_READ
  } nand_op_e;

  // flash command bytes
  typedef enum logic [7:0] {
    CMD_READ1   = 8'h00,
    CMD_READ2   = 8'h30,
    CMD_ERASE1  = 8'h60,
    CMD_STATUS  = 8'h70,
    CMD_PROG1   = 8'h80,
    CMD_READ_ID = 8'h90,
    CMD_PROG2   = 8'h10,
    CMD_ERASE2  = 8'hD0,
    CMD_RESET   = 8'hFF
  } nand_cmd_e;

  // cycle kinds understood by the toggle engine
  typedef enum logic [2:0] {
    CYC_CMD     = 3'b000,
    CYC_ADDR    = 3'b001,
    CYC_REG_RD  = 3'b010,
    CYC_DATA_RD = 3'b101,
    CYC_DATA_WR = 3'b111
  } cycle_code_e;

  typedef enum logic [1:0] {
    CAD_DATA = 2'b00,
    CAD_ADDR = 2'b10,
    CAD_CMD  = 2'b11
  } cad_sel_e;

  typedef enum logic [2:0] {
    AMUX_COL1, AMUX_COL2, AMUX_ROW1, AMUX_ROW2, AMUX_ROW3
  } amux_sel_e;

  // sequencer states, grouped by operation
  typedef enum logic [5:0] {
    S_IDLE, S_DECODE, S_DONE,
    S_RST_CL, S_RST_CMD, S_RST_CLR, S_RST_TWB, S_RST_BUSY,
    S_STS_CL, S_STS_CMD, S_STS_CLR, S_STS_TCLR, S_STS_RD,
    S_ID_CL, S_ID_CMD, S_ID_ACL, S_ID_ADDR,
    S_ID_RD0, S_ID_RD1, S_ID_RD2, S_ID_RD3, S_ID_RD4, S_ID_RD5,
    S_ERS_CL, S_ERS_CMD, S_ERS_CL2, S_ERS_CMD2, S_ERS_CLR, S_ERS_TWB, S_ERS_BUSY,
    S_PRG_CL, S_PRG_CMD, S_PRG_CLR, S_PRG_TCLR, S_PRG_BUSY, S_PRG_DATA,
    S_PRG_CL2, S_PRG_CMD2, S_PRG_CLR2, S_PRG_TCLR2, S_PRG_BUSY2,
    S_RD_CL, S_RD_CMD, S_RD_CL2, S_RD_CMD2, S_RD_CLR, S_RD_TCLR, S_RD_BUSY,
    S_RD_DATA, S_RD_DRAIN,
    S_ADR_COL1, S_ADR_COL2, S_ADR_ROW1, S_ADR_ROW2, S_ADR_ROW3
  } seq_state_e;

endpackage

//--- verilog/nand_cmd_decode.sv
`timescale 1ns/10ps

module nand_cmd_decode (
  input  logic              clk,
  input  logic              rstn,
  input  logic              start_i,
  input  logic [15:0]       command_i,
  output nand_pkg::nand_op_e op_o,
  output logic              id_long_o
);

  import nand_pkg::*;

  nand_op_e op_d;

  // match the host word against the supported commands
  always_comb begin
    casez (command_i)
      16'hFF00: op_d = OP_RESET;
      16'h7000: op_d = OP_STATUS;
      // low byte selects the ID length only
      16'h90??: op_d = OP_READ_ID;
      16'h60D0: op_d = OP_ERASE;
      16'h8010: op_d = OP_PROGRAM;
      16'h0030: op_d = OP_PAGE_READ;
      default:  op_d = OP_NONE;
    endcase
  end

  // captured on start, held until the next one
  always_ff @(posedge clk) begin
    if (!rstn) begin
      op_o      <= OP_NONE;
      id_long_o <= 1'b0;
    end else if (start_i) begin
      op_o      <= op_d;
      // 9020 asks for the 6 byte ID
      id_long_o <= command_i[5];
    end
  end

endmodule

//--- verilog/nand_wait_timer.sv
`timescale 1ns/10ps

module nand_wait_timer (
  input  logic clk,
  input  logic rstn,
  input  logic clr_i,
  input  logic run_i,
  output logic tclr_o,
  output logic twb_o
);

  import nand_pkg::*;

  logic [TMR_CNT_W-1:0] cnt_q;
  logic                 cnt_max;

  // stop at the longest delay so both flags stay up
  assign cnt_max = (cnt_q == TMR_CNT_W'(T_WB_CYC));

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt_q <= '0;
    end else if (clr_i) begin
      cnt_q <= '0;
    end else if (run_i && !cnt_max) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // level flags, high from the target count onwards
  assign tclr_o = (cnt_q >= TMR_CNT_W'(T_CLR_CYC));
  assign twb_o  = (cnt_q >= TMR_CNT_W'(T_WB_CYC));

endmodule

//--- verilog/nand_seq_fsm.sv
`timescale 1ns/10ps

module nand_seq_fsm (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic                               start_i,
  input  nand_pkg::nand_op_e                 op_i,
  input  logic                               id_long_i,
  input  logic                               rnb_i,
  input  logic                               toggle_done_i,
  input  logic                               interface_i,
  input  logic                               address_num_i,
  input  logic                               page_width_i,
  input  logic [nand_pkg::FIFO_CNT_W-1:0]    fifo_rdata_cnt_i,
  input  logic [nand_pkg::FIELD_W-1:0]       data_field_i,
  input  logic                               tclr_i,
  input  logic                               twb_i,
  output logic                               timer_clr_o,
  output logic                               timer_run_o,
  output logic                               toggle_en_o,
  output nand_pkg::cycle_code_e              cycle_code_o,
  output nand_pkg::nand_cmd_e                cmd_o,
  output logic                               cmd_en_o,
  output logic                               radr_en_o,
  output logic                               cadr_en_o,
  output logic                               acnt_rst_o,
  output logic                               ce_n_o,
  output logic [nand_pkg::REG_ADDR_W-1:0]    reg_addr_o,
  output nand_pkg::cad_sel_e                 cad_sel_o,
  output nand_pkg::amux_sel_e                amux_sel_o,
  output logic                               op_done_o,
  output logic                               flash_read_o,
  output logic                               flash_write_o
);

  import nand_pkg::*;

  seq_state_e state_q;
  seq_state_e state_d;
  seq_state_e addr_tail;
  nand_op_e   op_q;
  logic       id_long_q;
  logic       drain_end;

  // page read finishes once the fifo holds the whole field
  assign drain_end = (fifo_rdata_cnt_i ==
                      ({{(FIFO_CNT_W-FIELD_W){1'b0}}, data_field_i} + FIFO_CNT_W'(1)));

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q   <= S_IDLE;
      op_q      <= OP_NONE;
      id_long_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // keep the op for the shared address states
      if (state_q == S_DECODE) begin
        op_q      <= op_i;
        id_long_q <= id_long_i;
      end
    end
  end

  // where the shared address run hands over
  always_comb begin
    case (op_q)
      OP_ERASE:   addr_tail = S_ERS_CL2;
      OP_PROGRAM: addr_tail = S_PRG_CLR;
      default:    addr_tail = interface_i ? S_RD_CL2 : S_RD_CLR;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:   if (start_i) state_d = S_DECODE;
      S_DECODE: begin
        case (op_i)
          OP_RESET:     state_d = S_RST_CL;
          OP_STATUS:    state_d = S_STS_CL;
          OP_READ_ID:   state_d = S_ID_CL;
          OP_ERASE:     state_d = S_ERS_CL;
          OP_PROGRAM:   state_d = S_PRG_CL;
          OP_PAGE_READ: state_d = S_RD_CL;
          default:      state_d = S_IDLE;
        endcase
      end
      S_DONE:      state_d = S_IDLE;

      // reset
      S_RST_CL:    state_d = S_RST_CMD;
      S_RST_CMD:   if (toggle_done_i) state_d = S_RST_CLR;
      S_RST_CLR:   state_d = S_RST_TWB;
      S_RST_TWB:   if (twb_i) state_d = S_RST_BUSY;
      S_RST_BUSY:  if (rnb_i) state_d = S_DONE;

      // status read, also the tail of erase and program
      S_STS_CL:    state_d = S_STS_CMD;
      S_STS_CMD:   if (toggle_done_i) state_d = S_STS_CLR;
      S_STS_CLR:   state_d = S_STS_TCLR;
      S_STS_TCLR:  if (tclr_i) state_d = S_STS_RD;
      S_STS_RD:    if (toggle_done_i) state_d = S_DONE;

      // read ID
      S_ID_CL:     state_d = S_ID_CMD;
      S_ID_CMD:    if (toggle_done_i) state_d = S_ID_ACL;
      S_ID_ACL:    state_d = S_ID_ADDR;
      S_ID_ADDR:   if (toggle_done_i) state_d = S_ID_RD0;
      S_ID_RD0:    if (toggle_done_i) state_d = S_ID_RD1;
      S_ID_RD1:    if (toggle_done_i) state_d = S_ID_RD2;
      S_ID_RD2:    if (toggle_done_i) state_d = S_ID_RD3;
      S_ID_RD3:    if (toggle_done_i) state_d = id_long_q ? S_ID_RD4 : S_DONE;
      S_ID_RD4:    if (toggle_done_i) state_d = S_ID_RD5;
      S_ID_RD5:    if (toggle_done_i) state_d = S_DONE;

      // block erase, rows only
      S_ERS_CL:    state_d = S_ERS_CMD;
      S_ERS_CMD:   if (toggle_done_i) state_d = S_ADR_ROW1;
      S_ERS_CL2:   state_d = S_ERS_CMD2;
      S_ERS_CMD2:  if (toggle_done_i) state_d = S_ERS_CLR;
      S_ERS_CLR:   state_d = S_ERS_TWB;
      S_ERS_TWB:   if (twb_i) state_d = S_ERS_BUSY;
      S_ERS_BUSY:  if (rnb_i) state_d = S_STS_CL;

      // page program
      S_PRG_CL:    state_d = S_PRG_CMD;
      S_PRG_CMD:   if (toggle_done_i) state_d = S_ADR_COL1;
      S_PRG_CLR:   state_d = S_PRG_TCLR;
      S_PRG_TCLR:  if (tclr_i) state_d = S_PRG_BUSY;
      S_PRG_BUSY:  if (rnb_i) state_d = S_PRG_DATA;
      S_PRG_DATA:  if (toggle_done_i) state_d = S_PRG_CL2;
      S_PRG_CL2:   state_d = S_PRG_CMD2;
      S_PRG_CMD2:  if (toggle_done_i) state_d = S_PRG_CLR2;
      S_PRG_CLR2:  state_d = S_PRG_TCLR2;
      S_PRG_TCLR2: if (tclr_i) state_d = S_PRG_BUSY2;
      S_PRG_BUSY2: if (rnb_i) state_d = S_STS_CL;

      // page read
      S_RD_CL:     state_d = S_RD_CMD;
      S_RD_CMD:    if (toggle_done_i) state_d = S_ADR_COL1;
      S_RD_CL2:    state_d = S_RD_CMD2;
      S_RD_CMD2:   if (toggle_done_i) state_d = S_RD_CLR;
      S_RD_CLR:    state_d = S_RD_TCLR;
      S_RD_TCLR:   if (tclr_i) state_d = S_RD_BUSY;
      S_RD_BUSY:   if (rnb_i) state_d = S_RD_DATA;
      S_RD_DATA:   if (toggle_done_i) state_d = S_RD_DRAIN;
      S_RD_DRAIN:  if (drain_end) state_d = S_DONE;

      // address bytes, shared by erase, program and page read
      S_ADR_COL1:  if (toggle_done_i) state_d = page_width_i ? S_ADR_COL2 : S_ADR_ROW1;
      S_ADR_COL2:  if (toggle_done_i) state_d = S_ADR_ROW1;
      S_ADR_ROW1:  if (toggle_done_i) state_d = S_ADR_ROW2;
      S_ADR_ROW2:  if (toggle_done_i) state_d = address_num_i ? S_ADR_ROW3 : addr_tail;
      S_ADR_ROW3:  if (toggle_done_i) state_d = addr_tail;
      default:     state_d = S_IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state decodes
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    timer_clr_o   = 1'b0;
    timer_run_o   = 1'b0;
    toggle_en_o   = 1'b0;
    cycle_code_o  = CYC_CMD;
    cmd_o         = CMD_READ1;
    cmd_en_o      = 1'b0;
    radr_en_o     = 1'b0;
    cadr_en_o     = 1'b0;
    acnt_rst_o    = 1'b0;
    ce_n_o        = 1'b1;
    reg_addr_o    = '0;
    cad_sel_o     = CAD_CMD;
    amux_sel_o    = AMUX_COL1;
    op_done_o     = 1'b0;
    flash_read_o  = 1'b0;
    flash_write_o = 1'b0;
    case (state_q)
      S_DECODE: acnt_rst_o = 1'b1;
      S_DONE:   op_done_o = 1'b1;

      // command latch, one cycle each
      S_RST_CL: begin
        cmd_en_o = 1'b1;
        cmd_o    = CMD_RESET;
      end
      S_STS_CL: begin
        cmd_en_o = 1'b1;
        cmd_o    = CMD_STATUS;
      end
      S_ID_CL: begin
        cmd_en_o = 1'b1;
        cmd_o    = CMD_READ_ID;
      end
      // 00h goes out as the ID address byte
      S_ID_ACL: begin
        cmd_en_o = 1'b1;
        cmd_o    = CMD_READ1;
      end
      S_ERS_CL: begin
        cmd_en_o  = 1'b1;
        cmd_o     = CMD_ERASE1;
        radr_en_o = 1'b1;
      end
      S_ERS_CL2: begin
        cmd_en_o = 1'b1;
        cmd_o    = CMD_ERASE2;
      end
      S_PRG_CL: begin
        cmd_en_o  = 1'b1;
        cmd_o     = CMD_PROG1;
        radr_en_o = 1'b1;
        cadr_en_o = 1'b1;
      end
      S_PRG_CL2: begin
        cmd_en_o = 1'b1;
        cmd_o    = CMD_PROG2;
      end
      S_RD_CL: begin
        cmd_en_o  = 1'b1;
        cmd_o     = CMD_READ1;
        radr_en_o = 1'b1;
        cadr_en_o = 1'b1;
      end
      S_RD_CL2: begin
        cmd_en_o = 1'b1;
        cmd_o    = CMD_READ2;
      end

      // command bus cycles
      S_RST_CMD, S_STS_CMD, S_ID_CMD, S_ERS_CMD, S_ERS_CMD2,
      S_PRG_CMD, S_PRG_CMD2, S_RD_CMD, S_RD_CMD2: toggle_en_o = 1'b1;

      S_ID_ADDR: begin
        toggle_en_o  = 1'b1;
        cycle_code_o = CYC_ADDR;
      end
      S_ADR_COL1, S_ADR_COL2, S_ADR_ROW1, S_ADR_ROW2, S_ADR_ROW3: begin
        toggle_en_o  = 1'b1;
        cycle_code_o = CYC_ADDR;
        cad_sel_o    = CAD_ADDR;
        case (state_q)
          S_ADR_COL2: amux_sel_o = AMUX_COL2;
          S_ADR_ROW1: amux_sel_o = AMUX_ROW1;
          S_ADR_ROW2: amux_sel_o = AMUX_ROW2;
          S_ADR_ROW3: amux_sel_o = AMUX_ROW3;
          default:    amux_sel_o = AMUX_COL1;
        endcase
      end

      // delay timer
      S_RST_CLR, S_STS_CLR, S_ERS_CLR, S_PRG_CLR2: timer_clr_o = 1'b1;
      S_RST_TWB, S_STS_TCLR, S_ERS_TWB, S_PRG_TCLR, S_PRG_TCLR2: timer_run_o = 1'b1;
      // reload the column address before the data phase
      S_PRG_CLR: begin
        timer_clr_o = 1'b1;
        acnt_rst_o  = 1'b1;
        cadr_en_o   = 1'b1;
      end
      // CE stays low from the wait through the data read
      S_RD_CLR: begin
        timer_clr_o = 1'b1;
        ce_n_o      = 1'b0;
      end
      S_RD_TCLR: begin
        timer_run_o = 1'b1;
        ce_n_o      = 1'b0;
      end
      S_RD_BUSY: ce_n_o = 1'b0;

      // register reads
      S_STS_RD: begin
        toggle_en_o  = 1'b1;
        cycle_code_o = CYC_REG_RD;
        reg_addr_o   = REG_STATUS;
      end
      S_ID_RD0, S_ID_RD1, S_ID_RD2, S_ID_RD3, S_ID_RD4, S_ID_RD5: begin
        toggle_en_o  = 1'b1;
        cycle_code_o = CYC_REG_RD;
        case (state_q)
          S_ID_RD1: reg_addr_o = REG_ID_BASE + 12'd1;
          S_ID_RD2: reg_addr_o = REG_ID_BASE + 12'd2;
          S_ID_RD3: reg_addr_o = REG_ID_BASE + 12'd3;
          S_ID_RD4: reg_addr_o = REG_ID_BASE + 12'd4;
          S_ID_RD5: reg_addr_o = REG_ID_BASE + 12'd5;
          default:  reg_addr_o = REG_ID_BASE;
        endcase
      end

      // page data
      S_PRG_DATA: begin
        toggle_en_o   = 1'b1;
        cycle_code_o  = CYC_DATA_WR;
        cad_sel_o     = CAD_DATA;
        flash_write_o = 1'b1;
      end
      S_RD_DATA: begin
        toggle_en_o  = 1'b1;
        cycle_code_o = CYC_DATA_RD;
        cad_sel_o    = CAD_DATA;
        flash_read_o = 1'b1;
        ce_n_o       = 1'b0;
      end
      S_RD_DRAIN: flash_read_o = 1'b1;
      default: ;
    endcase
  end

endmodule

//--- verilog/nand_ctrl_top.sv
`timescale 1ns/10ps

module nand_ctrl_top (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic                               start_i,
  input  logic [15:0]                        command_i,
  input  logic                               rnb_i,
  input  logic                               toggle_done_i,
  input  logic                               interface_i,
  input  logic                               address_num_i,
  input  logic                               page_width_i,
  input  logic [nand_pkg::FIFO_CNT_W-1:0]    fifo_rdata_cnt_i,
  input  logic [nand_pkg::FIELD_W-1:0]       data_field_i,
  output logic                               toggle_en_o,
  output nand_pkg::cycle_code_e              cycle_code_o,
  output nand_pkg::nand_cmd_e                cmd_o,
  output logic                               cmd_en_o,
  output logic                               radr_en_o,
  output logic                               cadr_en_o,
  output logic                               acnt_rst_o,
  output logic                               ce_n_o,
  output logic [nand_pkg::REG_ADDR_W-1:0]    reg_addr_o,
  output nand_pkg::cad_sel_e                 cad_sel_o,
  output nand_pkg::amux_sel_e                amux_sel_o,
  output logic                               op_done_o,
  output logic                               flash_read_o,
  output logic                               flash_write_o
);

  import nand_pkg::*;

  nand_op_e op;
  logic     id_long;
  logic     timer_clr;
  logic     timer_run;
  logic     tclr_done;
  logic     twb_done;

  // host command, one cycle ahead of the decode state
  nand_cmd_decode u_decode (
    .clk       (clk),
    .rstn      (rstn),
    .start_i   (start_i),
    .command_i (command_i),
    .op_o      (op),
    .id_long_o (id_long)
  );

  // tCLR and tWB gaps
  nand_wait_timer u_timer (
    .clk    (clk),
    .rstn   (rstn),
    .clr_i  (timer_clr),
    .run_i  (timer_run),
    .tclr_o (tclr_done),
    .twb_o  (twb_done)
  );

  nand_seq_fsm u_fsm (
    .clk              (clk),
    .rstn             (rstn),
    .start_i          (start_i),
    .op_i             (op),
    .id_long_i        (id_long),
    .rnb_i            (rnb_i),
    .toggle_done_i    (toggle_done_i),
    .interface_i      (interface_i),
    .address_num_i    (address_num_i),
    .page_width_i     (page_width_i),
    .fifo_rdata_cnt_i (fifo_rdata_cnt_i),
    .data_field_i     (data_field_i),
    .tclr_i           (tclr_done),
    .twb_i            (twb_done),
    .timer_clr_o      (timer_clr),
    .timer_run_o      (timer_run),
    .toggle_en_o      (toggle_en_o),
    .cycle_code_o     (cycle_code_o),
    .cmd_o            (cmd_o),
    .cmd_en_o         (cmd_en_o),
    .radr_en_o        (radr_en_o),
    .cadr_en_o        (cadr_en_o),
    .acnt_rst_o       (acnt_rst_o),
    .ce_n_o           (ce_n_o),
    .reg_addr_o       (reg_addr_o),
    .cad_sel_o        (cad_sel_o),
    .amux_sel_o       (amux_sel_o),
    .op_done_o        (op_done_o),
    .flash_read_o     (flash_read_o),
    .flash_write_o    (flash_write_o)
  );

endmodule

//--- bench/nand_ctrl_assert.sv
`timescale 1ns/10ps

module nand_ctrl_assert (
  input logic clk,
  input logic rstn,
  input logic toggle_en_i,
  input logic toggle_done_i,
  input logic cmd_en_i,
  input logic op_done_i,
  input logic ce_n_i,
  input logic flash_read_i,
  input logic flash_write_i
);

  // bus cycle request stays up until the engine answers
  property toggle_held_p;
    @(posedge clk) disable iff (!rstn)
      (toggle_en_i && !toggle_done_i) |=> toggle_en_i;
  endproperty

  property cmd_en_single_p;
    @(posedge clk) disable iff (!rstn)
      cmd_en_i |=> !cmd_en_i;
  endproperty

  // done is one pulse, then the bus is idle
  property op_done_single_p;
    @(posedge clk) disable iff (!rstn)
      op_done_i |=> (!op_done_i && !toggle_en_i && !cmd_en_i && ce_n_i);
  endproperty

  property rd_wr_excl_p;
    @(posedge clk) disable iff (!rstn)
      !(flash_read_i && flash_write_i);
  endproperty

  toggle_held_a: assert property (toggle_held_p)
    else $error("toggle_en_o dropped before toggle_done_i");
  cmd_en_single_a: assert property (cmd_en_single_p)
    else $error("cmd_en_o lasted more than one cycle");
  op_done_single_a: assert property (op_done_single_p)
    else $error("op_done_o was not a single cycle followed by idle");
  rd_wr_excl_a: assert property (rd_wr_excl_p)
    else $error("flash_read_o and flash_write_o were high together");

endmodule

bind nand_ctrl_top nand_ctrl_assert u_assert (
  .clk           (clk),
  .rstn          (rstn),
  .toggle_en_i   (toggle_en_o),
  .toggle_done_i (toggle_done_i),
  .cmd_en_i      (cmd_en_o),
  .op_done_i     (op_done_o),
  .ce_n_i        (ce_n_o),
  .flash_read_i  (flash_read_o),
  .flash_write_i (flash_write_o)
);

//--- bench/nand_ctrl_tb.sv
`timescale 1ns/10ps

module nand_ctrl_tb;

  import nand_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int TEST_MAX_CYC = 250;
  localparam int QUIET_CYC    = 20;
  localparam int NUM_TESTS    = 15;

  typedef enum logic [2:0] {EV_CMD, EV_ADDR, EV_REG, EV_WR, EV_RD, EV_DONE} ev_kind_e;
  typedef struct packed {
    ev_kind_e    kind;
    logic [11:0] val;
  } ev_t;

  logic                  clk = 1'b0;
  logic                  rstn;
  logic                  start_i;
  logic [15:0]           command_i;
  logic                  rnb_i = 1'b1;
  logic                  toggle_done_i = 1'b0;
  logic                  interface_i;
  logic                  address_num_i;
  logic                  page_width_i;
  logic [FIFO_CNT_W-1:0] fifo_rdata_cnt_i = '0;
  logic [FIELD_W-1:0]    data_field_i;
  logic                  toggle_en_o;
  cycle_code_e           cycle_code_o;
  nand_cmd_e             cmd_o;
  logic                  cmd_en_o;
  logic                  radr_en_o;
  logic                  cadr_en_o;
  logic                  acnt_rst_o;
  logic                  ce_n_o;
  logic [REG_ADDR_W-1:0] reg_addr_o;
  cad_sel_e              cad_sel_o;
  amux_sel_e             amux_sel_o;
  logic                  op_done_o;
  logic                  flash_read_o;
  logic                  flash_write_o;

  ev_t                   exp_q[$];
  logic [15:0]           lfsr_q = 16'd39;
  int                    err_cnt = 0;
  int                    tests_run = 0;
  int                    tests_failed = 0;
  logic [FIFO_CNT_W-1:0] last_rd_cnt = '0;

  // flash model state
  logic                  done_nxt = 1'b0;
  logic                  rnb_nxt = 1'b1;
  logic [FIFO_CNT_W-1:0] cnt_nxt = '0;
  int unsigned           done_wait = 0;
  int unsigned           busy_left = 0;
  nand_cmd_e             last_cmd = CMD_READ1;

  always #(CLK_PERIOD / 2) clk = ~clk;

  nand_ctrl_top uut (.*);

  //////////////////////////////////////////////////////////////////////
  // random source
  //////////////////////////////////////////////////////////////////////

  // galois form of x^16+x^14+x^13+x^11+1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0])
      return (s >> 1) ^ 16'hB400;
    return s >> 1;
  endfunction

  function automatic int unsigned take_bits(input int n);
    int unsigned val;
    int          i;
    val = 0;
    for (i = 0; i < n; i++) begin
      val    = (val << 1) | {31'h0, lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return val;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // expected bus events
  //////////////////////////////////////////////////////////////////////

  function automatic void push_ev(input ev_kind_e kind, input logic [11:0] val);
    ev_t e;
    e.kind = kind;
    e.val  = val;
    exp_q.push_back(e);
  endfunction

  function automatic void add_status();
    push_ev(EV_CMD, {4'h0, CMD_STATUS});
    push_ev(EV_REG, REG_STATUS);
  endfunction

  // erase skips the column bytes
  function automatic void add_addr(input logic cols, input logic pwidth, input logic anum);
    if (cols)
      push_ev(EV_ADDR, {7'h0, CAD_ADDR, AMUX_COL1});
    if (cols && pwidth)
      push_ev(EV_ADDR, {7'h0, CAD_ADDR, AMUX_COL2});
    push_ev(EV_ADDR, {7'h0, CAD_ADDR, AMUX_ROW1});
    push_ev(EV_ADDR, {7'h0, CAD_ADDR, AMUX_ROW2});
    if (anum)
      push_ev(EV_ADDR, {7'h0, CAD_ADDR, AMUX_ROW3});
  endfunction

  function automatic void build_expected(input logic [15:0] word, input logic iface,
                                         input logic anum, input logic pwidth,
                                         input logic [FIELD_W-1:0] field);
    logic [11:0] done_val;
    int          n_id;
    int          i;
    // the final fifo count for page read and zero otherwise
    done_val = 12'h000;
    exp_q.delete();
    casez (word)
      16'hFF00: push_ev(EV_CMD, {4'h0, CMD_RESET});
      16'h7000: add_status();
      16'h90??: begin
        n_id = word[5] ? 6 : 4;
        push_ev(EV_CMD, {4'h0, CMD_READ_ID});
        // the 00h ID address goes through the command latch and out on the command source
        push_ev(EV_CMD, {4'h0, CMD_READ1});
        push_ev(EV_ADDR, {7'h0, CAD_CMD, AMUX_COL1});
        for (i = 0; i < n_id; i++)
          push_ev(EV_REG, REG_ID_BASE + REG_ADDR_W'(i));
      end
      16'h60D0: begin
        push_ev(EV_CMD, {4'h0, CMD_ERASE1});
        add_addr(1'b0, pwidth, anum);
        push_ev(EV_CMD, {4'h0, CMD_ERASE2});
        add_status();
      end
      16'h8010: begin
        push_ev(EV_CMD, {4'h0, CMD_PROG1});
        add_addr(1'b1, pwidth, anum);
        push_ev(EV_WR, 12'h000);
        push_ev(EV_CMD, {4'h0, CMD_PROG2});
        add_status();
      end
      16'h0030: begin
        push_ev(EV_CMD, {4'h0, CMD_READ1});
        add_addr(1'b1, pwidth, anum);
        if (iface)
          push_ev(EV_CMD, {4'h0, CMD_READ2});
        push_ev(EV_RD, 12'h000);
        done_val = field + 12'd1;
      end
      default: return;
    endcase
    push_ev(EV_DONE, done_val);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic report_error(input string msg);
    $display("%s", msg);
    err_cnt++;
  endtask

  task automatic check_cmd(input nand_cmd_e exp, input nand_cmd_e act);
    if (act !== exp) begin
      $display("FAIL cmd_o expected %h got %h", exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_amux(input amux_sel_e exp, input amux_sel_e act);
    if (act !== exp) begin
      $display("FAIL amux_sel_o expected %h got %h", exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_cad(input cad_sel_e exp, input cad_sel_e act);
    if (act !== exp) begin
      $display("FAIL cad_sel_o expected %h got %h", exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_reg(input logic [REG_ADDR_W-1:0] exp, input logic [REG_ADDR_W-1:0] act);
    if (act !== exp) begin
      $display("FAIL reg_addr_o expected %h got %h", exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_count(input logic [FIFO_CNT_W-1:0] exp,
                             input logic [FIFO_CNT_W-1:0] act);
    if (act !== exp) begin
      $display("FAIL fifo_rdata_cnt_i expected %h got %h", exp, act);
      err_cnt++;
    end
  endtask

  function automatic string kind_text(input ev_kind_e kind);
    case (kind)
      EV_CMD:  return "command latch";
      EV_ADDR: return "address cycle";
      EV_REG:  return "register read";
      EV_WR:   return "data write";
      EV_RD:   return "data read";
      default: return "op done";
    endcase
  endfunction

  task automatic match_event(input ev_kind_e kind, input logic [11:0] act);
    ev_t e;
    if (exp_q.size() == 0) begin
      report_error({"unexpected ", kind_text(kind), " when nothing more was expected"});
      return;
    end
    e = exp_q.pop_front();
    if (e.kind != kind) begin
      report_error({"expected a ", kind_text(e.kind), " but saw a ", kind_text(kind)});
      return;
    end
    case (kind)
      EV_CMD:  check_cmd(nand_cmd_e'(e.val[7:0]), nand_cmd_e'(act[7:0]));
      EV_ADDR: begin
        check_amux(amux_sel_e'(e.val[2:0]), amux_sel_e'(act[2:0]));
        check_cad(cad_sel_e'(e.val[4:3]), cad_sel_e'(act[4:3]));
      end
      EV_REG:  check_reg(e.val, act);
      EV_DONE: if (e.val != 12'h000) check_count(FIFO_CNT_W'(e.val), last_rd_cnt);
      default: ;
    endcase
  endtask

  // bus monitor sampled mid-cycle
  always @(negedge clk) begin
    if (rstn) begin
      if (flash_read_o)
        last_rd_cnt = fifo_rdata_cnt_i;
      if (cmd_en_o)
        match_event(EV_CMD, {4'h0, cmd_o});
      if (toggle_en_o && toggle_done_i) begin
        case (cycle_code_o)
          CYC_CMD:    check_cad(CAD_CMD, cad_sel_o);
          CYC_ADDR:   match_event(EV_ADDR, {7'h0, cad_sel_o, amux_sel_o});
          CYC_REG_RD: match_event(EV_REG, reg_addr_o);
          CYC_DATA_WR: begin
            if (!flash_write_o)
              report_error("flash_write_o was low during the write data cycle");
            check_cad(CAD_DATA, cad_sel_o);
            match_event(EV_WR, 12'h000);
          end
          CYC_DATA_RD: begin
            if (!flash_read_o)
              report_error("flash_read_o was low during the read data cycle");
            check_cad(CAD_DATA, cad_sel_o);
            match_event(EV_RD, 12'h000);
          end
          default: ;
        endcase
      end
      if (op_done_o)
        match_event(EV_DONE, 12'h000);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // flash and toggle engine model
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rstn) begin
      done_nxt  = 1'b0;
      rnb_nxt   = 1'b1;
      cnt_nxt   = '0;
      done_wait = 0;
      busy_left = 0;
    end else begin
      if (cmd_en_o)
        last_cmd = cmd_o;
      if (toggle_done_i) begin
        done_nxt  = 1'b0;
        done_wait = 0;
        // flash goes busy once 10h, D0h or FFh is on the bus
        if (cycle_code_o == CYC_CMD && (last_cmd == CMD_PROG2 ||
            last_cmd == CMD_ERASE2 || last_cmd == CMD_RESET))
          busy_left = 2 + take_bits(3);
      end else if (toggle_en_o) begin
        if (done_wait == 0)
          done_wait = 1 + take_bits(2);
        done_wait--;
        done_nxt = (done_wait == 0);
      end else begin
        done_nxt = 1'b0;
      end
      if (busy_left != 0) begin
        rnb_nxt = 1'b0;
        busy_left--;
      end else begin
        rnb_nxt = 1'b1;
      end
      if (start_i)
        cnt_nxt = '0;
      else if (flash_read_o)
        cnt_nxt = fifo_rdata_cnt_i + 32'd1;
    end
  end

  always @(posedge clk) begin
    #1;
    toggle_done_i    = done_nxt;
    rnb_i            = rnb_nxt;
    fifo_rdata_cnt_i = cnt_nxt;
  end

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (err_cnt == err_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, err_cnt - err_before);
      tests_failed++;
    end
  endtask

  task automatic run_test(input string name, input logic [15:0] word, input logic iface,
                          input logic anum, input logic pwidth);
    int err_before;
    int cyc;
    err_before = err_cnt;
    @(posedge clk);
    #1;
    interface_i   = iface;
    address_num_i = anum;
    page_width_i  = pwidth;
    // at least 8 so the data phase cannot overrun the field
    data_field_i  = FIELD_W'(8 + take_bits(6));
    build_expected(word, iface, anum, pwidth, data_field_i);
    command_i     = word;
    start_i       = 1'b1;
    @(posedge clk);
    #1;
    start_i = 1'b0;
    cyc = 0;
    while (exp_q.size() != 0 && cyc < TEST_MAX_CYC) begin
      @(posedge clk);
      cyc++;
    end
    if (exp_q.size() != 0) begin
      report_error($sformatf("%s timed out with %0d events still missing", name, exp_q.size()));
      exp_q.delete();
    end
    // also the quiet window after an unknown word
    repeat (QUIET_CYC) @(posedge clk);
    finish_test(name, err_before);
  endtask

  initial begin
    rstn          = 1'b0;
    start_i       = 1'b0;
    command_i     = 16'h0000;
    interface_i   = 1'b0;
    address_num_i = 1'b0;
    page_width_i  = 1'b0;
    data_field_i  = '0;
    repeat (4) @(posedge clk);
    #1;
    rstn = 1'b1;
    @(negedge clk);
    if (toggle_en_o || cmd_en_o || radr_en_o || cadr_en_o || acnt_rst_o || op_done_o ||
        flash_read_o || flash_write_o || !ce_n_o)
      report_error("a strobe was active or CE was low right after reset");
    finish_test("after_reset", 0);

    run_test("reset", 16'hFF00, 1'b0, 1'b0, 1'b0);
    run_test("read_status", 16'h7000, 1'b0, 1'b0, 1'b0);
    run_test("read_id_4", 16'h9000, 1'b0, 1'b0, 1'b0);
    run_test("read_id_6", 16'h9020, 1'b0, 1'b0, 1'b0);
    run_test("erase_2row", 16'h60D0, 1'b0, 1'b0, 1'b0);
    run_test("erase_3row", 16'h60D0, 1'b0, 1'b1, 1'b1);
    run_test("program_c1_r2", 16'h8010, 1'b0, 1'b0, 1'b0);
    run_test("program_c1_r3", 16'h8010, 1'b0, 1'b1, 1'b0);
    run_test("program_c2_r2", 16'h8010, 1'b0, 1'b0, 1'b1);
    run_test("program_c2_r3", 16'h8010, 1'b0, 1'b1, 1'b1);
    run_test("page_read_toggle", 16'h0030, 1'b1, 1'b1, 1'b1);
    run_test("page_read_legacy", 16'h0030, 1'b0, 1'b0, 1'b1);
    run_test("unknown_word", 16'h1234, 1'b0, 1'b0, 1'b0);
    run_test("status_after_unknown", 16'h7000, 1'b0, 1'b0, 1'b0);

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // worst case for every test plus reset
  initial begin
    #((NUM_TESTS * (TEST_MAX_CYC + QUIET_CYC + 2) + 8) * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("Regression failed");
    $finish;
  end

endmodule

//--- sim.f
verilog/nand_pkg.sv
verilog/nand_cmd_decode.sv
verilog/nand_wait_timer.sv
verilog/nand_seq_fsm.sv
verilog/nand_ctrl_top.sv
bench/nand_ctrl_assert.sv
bench/nand_ctrl_tb.sv

//--- Makefile
TOP := nand_ctrl_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory and the log"

obj_dir/V$(TOP): sim.f verilog/*.sv bench/*.sv
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o V$(TOP)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
